// ==== ifu_apb_rd.sv ====
`timescale 1ns/1ns

module ifu_apb_rd (
  input  logic           clk,
  input  logic           rst,
  input  logic           req_i,
  input  ifu_pkg::addr_t addr_i,
  output logic           done_o,
  output ifu_pkg::word_t data_o,
  output ifu_pkg::addr_t paddr_o,
  output logic           psel_o,
  output logic           penable_o,
  output logic           pwrite_o,
  input  ifu_pkg::word_t prdata_i,
  input  logic           pready_i
);
  import ifu_pkg::*;

  apb_state_t state_q;
  addr_t      paddr_q;
  word_t      data_q;
  logic       done_q;

  assign paddr_o   = paddr_q;
  assign psel_o    = (state_q != APB_IDLE);
  assign penable_o = (state_q == APB_ACCESS);
  assign pwrite_o  = 1'b0;
  assign done_o    = done_q;
  assign data_o    = data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= APB_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        // the requester still holds req in the cycle of done_o
        APB_IDLE: begin
          if (req_i && !done_q) begin
            state_q <= APB_SETUP;
          end
        end
        APB_SETUP: state_q <= APB_ACCESS;
        APB_ACCESS: begin
          if (pready_i) begin
            done_q  <= 1'b1;
            state_q <= APB_IDLE;
          end
        end
        default: state_q <= APB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == APB_IDLE) && req_i && !done_q) begin
      paddr_q <= addr_i;
    end
    if ((state_q == APB_ACCESS) && pready_i) begin
      data_q <= prdata_i;
    end
  end

endmodule

// ==== ifu_l1i.sv ====
`timescale 1ns/1ns

module ifu_l1i (
  input  logic           clk,
  input  logic           rst,
  input  ifu_pkg::addr_t fetch_pc_i,
  input  logic           flush_i,
  input  logic           fill_done_i,
  input  ifu_pkg::word_t fill_data_i,
  output ifu_pkg::word_t inst_o,
  output logic           hit_o,
  output logic           idle_o,
  output logic           fill_req_o,
  output ifu_pkg::addr_t fill_addr_o
);
  import ifu_pkg::*;

  localparam int SETS  = 2 ** L1I_IDX_W;
  localparam int WORDS = 2 ** L1I_OFS_W;

  word_t data_mem [SETS][WORDS];
  tag_t  tag_mem  [SETS];

  logic [SETS-1:0] valid_q;
  l1i_state_t      state_q;

  tag_t                 pc_tag;
  idx_t                 pc_idx;
  logic [L1I_OFS_W-1:0] pc_ofs;
  logic [L1I_OFS_W-1:0] fill_ofs;
  logic                 line_hit;
  logic                 filling;
  logic                 fill_wr;

  // pc = tag | index | word in line | byte
  assign pc_tag = fetch_pc_i[ADDR_W-1 -: L1I_TAG_W];
  assign pc_idx = fetch_pc_i[L1I_IDX_W+L1I_OFS_W+1 -: L1I_IDX_W];
  assign pc_ofs = fetch_pc_i[L1I_OFS_W+1 -: L1I_OFS_W];

  assign line_hit = valid_q[pc_idx] && (tag_mem[pc_idx] == pc_tag);

  assign idle_o = (state_q == L1I_IDLE);
  assign hit_o  = idle_o && line_hit;
  assign inst_o = data_mem[pc_idx][pc_ofs];

  // even word first, odd word second
  assign filling  = (state_q == L1I_FILL0) || (state_q == L1I_FILL1);
  assign fill_ofs = L1I_OFS_W'(state_q == L1I_FILL1);
  assign fill_wr  = filling && fill_done_i;

  // request rises in the miss cycle and holds until the second word returns
  assign fill_req_o  = (idle_o && !line_hit) || filling;
  assign fill_addr_o = {pc_tag, pc_idx, fill_ofs, 2'b00};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= L1I_IDLE;
      valid_q <= '0;
    end else begin
      if (flush_i) begin
        valid_q <= '0;
      end
      case (state_q)
        L1I_IDLE: begin
          if (!line_hit) begin
            state_q <= L1I_FILL0;
          end
        end
        L1I_FILL0: begin
          if (fill_done_i) begin
            state_q <= L1I_FILL1;
          end
        end
        L1I_FILL1: begin
          if (fill_done_i) begin
            state_q <= L1I_DONE;
          end
        end
        L1I_DONE: begin
          valid_q[pc_idx] <= 1'b1;
          state_q         <= L1I_IDLE;
        end
        default: state_q <= L1I_IDLE;
      endcase
    end
  end

  // line storage
  always_ff @(posedge clk) begin
    if (fill_wr) begin
      data_mem[pc_idx][fill_ofs] <= fill_data_i;
    end
    if (fill_wr && (state_q == L1I_FILL1)) begin
      tag_mem[pc_idx] <= pc_tag;
    end
  end

endmodule

// ==== ifu_pc_ctrl.sv ====
`timescale 1ns/1ns

module ifu_pc_ctrl (
  input  logic           clk,
  input  logic           rst,
  input  ifu_pkg::word_t inst_i,
  input  logic           hit_i,
  input  logic           idle_i,
  input  logic           next_ready_i,
  input  logic           pc_change_i,
  input  logic           pc_retire_i,
  input  ifu_pkg::addr_t npc_i,
  output ifu_pkg::addr_t fetch_pc_o,
  output logic           valid_o,
  output logic           flush_o
);
  import ifu_pkg::*;

  fetch_state_t state_q;
  addr_t        pc_q;
  logic         pend_q;
  addr_t        pend_pc_q;

  logic [6:0] opcode;
  logic       is_stall;
  logic       is_fence;
  logic       xfer;
  logic       feedback;
  logic       resume;
  addr_t      resume_pc;

  assign opcode   = inst_i[6:0];
  assign is_stall = (opcode == OP_JAL) || (opcode == OP_JALR) || (opcode == OP_BRANCH) ||
                    (opcode == OP_SYSTEM) || (opcode == OP_LOAD);
  assign is_fence = (inst_i == INST_FENCE_I);

  assign valid_o    = hit_i && (state_q == FETCH_RUN);
  assign xfer       = valid_o && next_ready_i;
  assign flush_o    = xfer && is_fence;
  assign fetch_pc_o = pc_q;

  // core feedback can land while the cache is still refilling after fence.i,
  // so it is remembered until the cache goes idle
  assign feedback = pc_change_i || pc_retire_i;
  assign resume   = feedback || pend_q;

  always_comb begin
    if (pc_change_i) begin
      resume_pc = npc_i;
    end else if (pc_retire_i) begin
      resume_pc = pc_q + 32'd4;
    end else begin
      resume_pc = pend_pc_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= FETCH_RUN;
      pc_q    <= PC_INIT;
      pend_q  <= 1'b0;
    end else begin
      case (state_q)
        FETCH_RUN: begin
          if (xfer) begin
            if (is_stall || is_fence) begin
              state_q <= FETCH_HOLD;
            end else begin
              pc_q <= pc_q + 32'd4;
            end
          end
        end
        FETCH_HOLD: begin
          if (resume && idle_i) begin
            pc_q    <= resume_pc;
            pend_q  <= 1'b0;
            state_q <= FETCH_RUN;
          end else if (feedback) begin
            pend_q <= 1'b1;
          end
        end
        default: state_q <= FETCH_RUN;
      endcase
    end
  end

  // target of feedback that arrived during a refill
  always_ff @(posedge clk) begin
    if ((state_q == FETCH_HOLD) && feedback) begin
      pend_pc_q <= resume_pc;
    end
  end

endmodule

// ==== ifu_pkg.sv ====
package ifu_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // 4 sets, 2 words per line
  localparam int L1I_IDX_W = 2;
  localparam int L1I_OFS_W = 1;
  localparam int L1I_TAG_W = ADDR_W - L1I_IDX_W - L1I_OFS_W - 2;

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    word_t;
  typedef logic [L1I_TAG_W-1:0] tag_t;
  typedef logic [L1I_IDX_W-1:0] idx_t;

  localparam addr_t PC_INIT = 32'h0000_0000;

  // opcodes that hold fetch until the core reports back
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;

  localparam word_t INST_FENCE_I = 32'h0000_100f;

  typedef enum logic {FETCH_RUN, FETCH_HOLD} fetch_state_t;

  typedef enum logic [1:0] {L1I_IDLE, L1I_FILL0, L1I_FILL1, L1I_DONE} l1i_state_t;

  typedef enum logic [1:0] {APB_IDLE, APB_SETUP, APB_ACCESS} apb_state_t;

endpackage

// ==== ifu_top.sv ====
`timescale 1ns/1ns

module ifu_top (
  input  logic           clk,
  input  logic           rst,
  output ifu_pkg::addr_t paddr_o,
  output logic           psel_o,
  output logic           penable_o,
  output logic           pwrite_o,
  input  ifu_pkg::word_t prdata_i,
  input  logic           pready_i,
  output ifu_pkg::word_t inst_o,
  output ifu_pkg::addr_t pc_o,
  output logic           valid_o,
  input  logic           next_ready_i,
  input  logic           pc_change_i,
  input  ifu_pkg::addr_t npc_i,
  input  logic           pc_retire_i
);
  import ifu_pkg::*;

  addr_t fetch_pc;
  logic  flush;
  logic  hit;
  logic  idle;
  word_t inst;
  logic  fill_req;
  addr_t fill_addr;
  logic  fill_done;
  word_t fill_data;

  assign inst_o = inst;
  assign pc_o   = fetch_pc;

  ifu_pc_ctrl u_pc_ctrl (
    .clk(clk), .rst(rst), .inst_i(inst), .hit_i(hit), .idle_i(idle),
    .next_ready_i(next_ready_i), .pc_change_i(pc_change_i),
    .pc_retire_i(pc_retire_i), .npc_i(npc_i), .fetch_pc_o(fetch_pc),
    .valid_o(valid_o), .flush_o(flush)
  );

  ifu_l1i u_l1i (
    .clk(clk), .rst(rst), .fetch_pc_i(fetch_pc), .flush_i(flush),
    .fill_done_i(fill_done), .fill_data_i(fill_data), .inst_o(inst), .hit_o(hit),
    .idle_o(idle), .fill_req_o(fill_req), .fill_addr_o(fill_addr)
  );

  ifu_apb_rd u_apb_rd (
    .clk(clk), .rst(rst), .req_i(fill_req), .addr_i(fill_addr), .done_o(fill_done),
    .data_o(fill_data), .paddr_o(paddr_o), .psel_o(psel_o), .penable_o(penable_o),
    .pwrite_o(pwrite_o), .prdata_i(prdata_i), .pready_i(pready_i)
  );

endmodule

// ==== project.f ====
ifu_pkg.sv
ifu_pc_ctrl.sv
ifu_l1i.sv
ifu_apb_rd.sv
ifu_top.sv
tb_apb_mem.sv
tb_ifu_assert.sv
tb_ifu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_ifu -f project.f -o tb_ifu_sim

./obj_dir/tb_ifu_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -q "Test FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failures"

// ==== tb_apb_mem.sv ====
`timescale 1ns/1ns

module tb_apb_mem (
  input  ifu_pkg::addr_t paddr_i,
  input  logic           psel_i,
  input  logic           penable_i,
  input  logic           stall_i,
  output ifu_pkg::word_t prdata_o,
  output logic           pready_o
);
  import ifu_pkg::*;

  // 1 KB image that higher addresses wrap onto
  word_t mem [256];

  assign prdata_o = mem[paddr_i[9:2]];

  // wait state in any access cycle where stall_i is high
  assign pready_o = psel_i && penable_i && !stall_i;

endmodule

// ==== tb_ifu.sv ====
`timescale 1ns/1ns

module tb_ifu;
  import ifu_pkg::*;

  localparam int NUM_TESTS  = 4;
  localparam int TEST_XFERS = 150;

  logic       clk        = 1'b0;
  logic       rst        = 1'b1;
  logic       next_ready = 1'b0;
  logic       pc_change  = 1'b0;
  logic       pc_retire  = 1'b0;
  addr_t      npc        = PC_INIT;
  logic       mem_stall  = 1'b0;
  logic       bp_on      = 1'b0;
  logic       ws_on      = 1'b0;
  logic       core_wait  = 1'b0;
  logic [1:0] core_cnt   = 2'd0;
  logic [15:0] lfsr      = 16'd98;
  int         xfer_cnt   = 0;

  addr_t paddr;
  addr_t pc;
  word_t prdata;
  word_t inst;
  logic  psel;
  logic  penable;
  logic  pwrite;
  logic  pready;
  logic  valid;

  ifu_top UUT (
    .clk(clk), .rst(rst), .paddr_o(paddr), .psel_o(psel), .penable_o(penable),
    .pwrite_o(pwrite), .prdata_i(prdata), .pready_i(pready), .inst_o(inst), .pc_o(pc),
    .valid_o(valid), .next_ready_i(next_ready), .pc_change_i(pc_change), .npc_i(npc),
    .pc_retire_i(pc_retire)
  );

  tb_apb_mem u_mem (
    .paddr_i(paddr), .psel_i(psel), .penable_i(penable), .stall_i(mem_stall),
    .prdata_o(prdata), .pready_o(pready)
  );

  always #4 clk = ~clk;

  // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic stalls(input word_t w);
    return (w[6:0] inside {OP_JAL, OP_JALR, OP_BRANCH, OP_SYSTEM, OP_LOAD}) ||
           (w == INST_FENCE_I);
  endfunction

  // mostly addi-type words, about one in six stalling, rare fence.i
  function automatic word_t make_inst();
    logic [4:0]  kind;
    logic [2:0]  pick;
    logic [6:0]  op;
    logic [31:0] hi;
    kind = 5'(rand_bits(5));
    pick = 3'(rand_bits(3));
    hi   = rand_bits(25);
    op   = 7'b0010011;
    if (kind == 5'd8) begin
      return INST_FENCE_I;
    end
    if (kind < 5'd8) begin
      case (pick)
        3'd0: op = OP_JAL;
        3'd1: op = OP_JALR;
        3'd2: op = OP_BRANCH;
        3'd3: op = OP_SYSTEM;
        3'd4: op = OP_LOAD;
        default: op = 7'b0010011;
      endcase
    end
    return {hi[24:0], op};
  endfunction

  // downstream ready, APB wait states and the core answering stalls
  always @(posedge clk) begin
    next_ready <= !bp_on || (rand_bits(2) != 0);
    mem_stall  <= ws_on && (rand_bits(1) != 0);
    pc_change  <= 1'b0;
    pc_retire  <= 1'b0;
    if (rst) begin
      core_wait <= 1'b0;
    end else if (valid && next_ready) begin
      xfer_cnt  <= xfer_cnt + 1;
      core_wait <= stalls(inst);
      core_cnt  <= 2'(rand_bits(2));
    end else if (core_wait) begin
      if (core_cnt == 2'd0) begin
        core_wait <= 1'b0;
        if (rand_bits(1) != 0) begin
          pc_change <= 1'b1;
          npc       <= rand_bits(8) << 2;
        end else begin
          pc_retire <= 1'b1;
        end
      end else begin
        core_cnt <= core_cnt - 2'd1;
      end
    end
  end

  task automatic run_test(input string name, input logic bp, input logic ws);
    int x0;
    int f0;
    rst   <= 1'b1;
    bp_on <= bp;
    ws_on <= ws;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    x0 = xfer_cnt;
    f0 = UUT.u_chk.fail_cnt;
    while (xfer_cnt - x0 < TEST_XFERS) begin
      @(posedge clk);
    end
    $display("%-14s %0d transfers, %0d assertion failures", name, xfer_cnt - x0,
             UUT.u_chk.fail_cnt - f0);
  endtask

  initial begin
    for (int i = 0; i < 256; i++) begin
      u_mem.mem[i] = make_inst();
    end
    run_test("full_rate", 1'b0, 1'b0);
    run_test("back_pressure", 1'b1, 1'b0);
    run_test("wait_states", 1'b0, 1'b1);
    run_test("mixed", 1'b1, 1'b1);
    $display("tests %0d, transfers %0d, assertion failures %0d", NUM_TESTS, xfer_cnt,
             UUT.u_chk.fail_cnt);
    if (UUT.u_chk.fail_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    repeat (NUM_TESTS * 2000) @(posedge clk);
    $display("timeout after %0d cycles with %0d transfers", NUM_TESTS * 2000, xfer_cnt);
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== tb_ifu_assert.sv ====
`timescale 1ns/1ns

module tb_ifu_assert (
  input logic           clk,
  input logic           rst,
  input ifu_pkg::addr_t paddr_o,
  input logic           psel_o,
  input logic           penable_o,
  input logic           pwrite_o,
  input ifu_pkg::word_t prdata_i,
  input logic           pready_i,
  input ifu_pkg::word_t inst_o,
  input ifu_pkg::addr_t pc_o,
  input logic           valid_o,
  input logic           next_ready_i,
  input logic           pc_change_i,
  input logic           pc_retire_i,
  input ifu_pkg::addr_t npc_i
);
  import ifu_pkg::*;

  int           fail_cnt = 0;
  word_t        shadow [256];
  logic [255:0] seen;
  addr_t        exp_pc;
  addr_t        paddr_prev;
  logic         hold_q;
  logic         xfer;
  logic         rd_done;
  logic         stall_op;
  logic         known;
  word_t        exp_inst;

  assign xfer     = valid_o && next_ready_i;
  assign rd_done  = psel_o && penable_o && pready_i;
  assign stall_op = (inst_o[6:0] inside {OP_JAL, OP_JALR, OP_BRANCH, OP_SYSTEM, OP_LOAD}) ||
                    (inst_o == INST_FENCE_I);
  assign known    = seen[pc_o[9:2]];
  assign exp_inst = shadow[pc_o[9:2]];

  // words read over APB are forgotten on reset and on fence.i
  always @(posedge clk) begin
    if (rst || (xfer && (inst_o == INST_FENCE_I))) begin
      seen <= '0;
    end else if (rd_done) begin
      seen[paddr_o[9:2]] <= 1'b1;
    end
    if (rd_done) begin
      shadow[paddr_o[9:2]] <= prdata_i;
    end
  end

  // bus address one cycle back
  always @(posedge clk) begin
    paddr_prev <= paddr_o;
  end

  // next pc the stream must show
  always @(posedge clk) begin
    if (rst) begin
      exp_pc <= PC_INIT;
      hold_q <= 1'b0;
    end else if (xfer) begin
      exp_pc <= pc_o + 32'd4;
      hold_q <= stall_op;
    end else if (pc_change_i || pc_retire_i) begin
      hold_q <= 1'b0;
      if (pc_change_i) begin
        exp_pc <= npc_i;
      end
    end
  end

  a_fetched: assert property (@(posedge clk) disable iff (rst) xfer |-> known)
    else begin
      fail_cnt++;
      $error("instruction at pc %h delivered without an APB read", $sampled(pc_o));
    end

  a_data: assert property (@(posedge clk) disable iff (rst) xfer && known |-> inst_o == exp_inst)
    else begin
      fail_cnt++;
      $error("mismatch inst_o %h expected %h", $sampled(inst_o), $sampled(exp_inst));
    end

  a_pc: assert property (@(posedge clk) disable iff (rst) xfer |-> pc_o == exp_pc)
    else begin
      fail_cnt++;
      $error("mismatch pc_o %h expected %h", $sampled(pc_o), $sampled(exp_pc));
    end

  a_hold: assert property (@(posedge clk) disable iff (rst) hold_q |-> !valid_o)
    else begin
      fail_cnt++;
      $error("valid_o high while fetch waits for the core");
    end

  a_backpressure: assert property (@(posedge clk) disable iff (rst)
      valid_o && !next_ready_i |=> valid_o && $stable(inst_o) && $stable(pc_o))
    else begin
      fail_cnt++;
      $error("instruction not held while next_ready_i was low");
    end

  a_setup: assert property (@(posedge clk) disable iff (rst)
      psel_o && !penable_o |=> psel_o && penable_o)
    else begin
      fail_cnt++;
      $error("APB setup cycle not followed by an access cycle");
    end

  a_enable: assert property (@(posedge clk) disable iff (rst)
      $rose(penable_o) |-> psel_o && $past(psel_o))
    else begin
      fail_cnt++;
      $error("penable_o rose without a setup cycle");
    end

  a_paddr: assert property (@(posedge clk) disable iff (rst)
      psel_o && !(penable_o && pready_i) |=> $stable(paddr_o))
    else begin
      fail_cnt++;
      $error("mismatch paddr_o %h expected %h", $sampled(paddr_o), $sampled(paddr_prev));
    end

  a_pwrite: assert property (@(posedge clk) disable iff (rst) !pwrite_o)
    else begin
      fail_cnt++;
      $error("mismatch pwrite_o %h expected 0", $sampled(pwrite_o));
    end

  a_reset: assert property (@(posedge clk) rst && $past(rst) |-> !valid_o && !psel_o && !penable_o)
    else begin
      fail_cnt++;
      $error("valid_o or APB select active during reset");
    end

endmodule

bind ifu_top tb_ifu_assert u_chk (.*);
